// ==== bench/unpack_tests.txt ====
# R reg value64 / I ctrl eew vs2_load vs2_narrow vs2_sigext vs2_addr vs1_load vs1_is_vreg vs1_src
#   exp_ctrl exp_vs2 exp_vs1 (all hex, eew 0/1/2 means 8/16/32 bits)
R 01 0123456789abcdef
R 02 fedcba9876543210
R 03 c3a59e01b24c7f81
R 04 5a5a00ff13579bdf
I 01 2 1 0 0 01 1 1 00000002 01 89abcdef 76543210
I 02 2 0 0 0 01 1 0 deadbeef 02 01234567 deadbeef
I 03 2 1 0 0 02 1 1 00000004 03 76543210 13579bdf
I 04 0 0 0 0 02 1 0 123456a7 04 fedcba98 a7a7a7a7
I 05 1 1 0 0 01 1 0 0000c3d4 05 89abcdef c3d4c3d4
I 06 1 0 0 0 01 1 1 00000001 06 01234567 89abcdef
I 07 1 1 1 1 03 1 0 00000080 07 007fff81 00800080
I 08 1 0 1 0 03 1 1 00000003 08 00b2004c b24c7f81
I 09 2 0 1 1 03 1 0 cafef00d 09 ffff9e01 cafef00d
I 0a 2 0 1 0 03 1 1 00000004 0a 0000c3a5 13579bdf
I 0b 0 1 0 0 04 1 0 000000ff 0b 13579bdf ffffffff
I 0c 0 0 0 0 04 1 1 00000002 0c 5a5a00ff 76543210

// ==== compile.f ====
+incdir+hdl
hdl/unpack_pkg.sv
hdl/unpack_pipe_ctrl.sv
hdl/operand_buffer.sv
hdl/operand_extract.sv
hdl/vreg_read_track.sv
hdl/vreg_unpack.sv
bench/vreg_unpack_properties.sv
bench/vreg_unpack_tb.sv

// ==== Bender.yml ====
package:
  name: vreg_unpack

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/unpack_pkg.sv
      - hdl/unpack_pipe_ctrl.sv
      - hdl/operand_buffer.sv
      - hdl/operand_extract.sv
      - hdl/vreg_read_track.sv
      - hdl/vreg_unpack.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/vreg_unpack_properties.sv
      - bench/vreg_unpack_tb.sv

// ==== bench/vreg_unpack_tb.sv ====
/*
 * testbench for vreg_unpack driven by bench/unpack_tests.txt
 * run from the project root so the data file path resolves
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module vreg_unpack_tb;

    import unpack_pkg::*;

    localparam int RST_CYCLES  = 4;
    localparam int HOLD_CYCLES = 16;

    typedef struct packed {
        logic [`UNPACK_CTRL_W-1:0] ctrl;
        logic [`UNPACK_OP_W-1:0]   vs2;
        logic [`UNPACK_OP_W-1:0]   vs1;
    } expect_t;

    logic                                 clk_i;
    logic                                 async_rst_ni;
    logic                                 pipe_in_valid_i;
    logic                                 pipe_in_ready_o;
    unpack_item_t                         pipe_in_item_i;
    logic                                 pipe_out_valid_o;
    logic                                 pipe_out_ready_i = 1'b0;
    logic [`UNPACK_CTRL_W-1:0]            pipe_out_ctrl_o;
    logic [`UNPACK_OP_W-1:0]              pipe_out_vs2_o;
    logic [`UNPACK_OP_W-1:0]              pipe_out_vs1_o;
    logic [1:0][`UNPACK_VADDR_W-1:0]      vreg_rd_addr_o;
    logic [1:0][`UNPACK_VPORT_W-1:0]      vreg_rd_data_i;
    logic [(1 << `UNPACK_VADDR_W)-1:0]    pending_vreg_reads_o;
    logic                                 stage_valid_any_o;

    logic [`UNPACK_VPORT_W-1:0]        regfile [1 << `UNPACK_VADDR_W];
    unpack_item_t                      items[$];
    expect_t                           exp_q[$];
    expect_t                           exp_item;
    logic [(1 << `UNPACK_VADDR_W)-1:0] want_mask;
    logic [31:0]                       rnd_state = 32'h6a41;
    int                                cycle_cnt = 0;
    int                                ctrl_errs = 0;
    int                                op_errs = 0;
    int                                mask_errs = 0;
    int                                other_errs = 0;
    bit                                loaded = 1'b0;

    vreg_unpack dut_i (.*);

    // register file answers in the same cycle
    assign vreg_rd_data_i[0] = regfile[vreg_rd_addr_o[0]];
    assign vreg_rd_data_i[1] = regfile[vreg_rd_addr_o[1]];

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // registers a waiting input item still has to read
    function automatic logic [(1 << `UNPACK_VADDR_W)-1:0] pending_bits(input unpack_item_t it);
        logic [(1 << `UNPACK_VADDR_W)-1:0] m;
        m = '0;
        if (it.vs2.load) begin
            m[it.vs2.src.vreg.vaddr] = 1'b1;
        end
        if (it.vs1.load && it.vs1.is_vreg) begin
            m[it.vs1.src.vreg.vaddr] = 1'b1;
        end
        return m;
    endfunction

    task automatic check_ctrl(input string name, input logic [`UNPACK_CTRL_W-1:0] got,
                              input logic [`UNPACK_CTRL_W-1:0] want);
        if (got !== want) begin
            ctrl_errs++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_op(input string name, input logic [`UNPACK_OP_W-1:0] got,
                            input logic [`UNPACK_OP_W-1:0] want);
        if (got !== want) begin
            op_errs++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_mask(input string name,
                              input logic [(1 << `UNPACK_VADDR_W)-1:0] got,
                              input logic [(1 << `UNPACK_VADDR_W)-1:0] want);
        if (got !== want) begin
            mask_errs++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic read_tests();
        int                         fd;
        int                         n;
        string                      line;
        logic [31:0]                f [12];
        logic [`UNPACK_VPORT_W-1:0] rd;
        unpack_item_t               it;
        expect_t                    e;
        for (int a = 0; a < (1 << `UNPACK_VADDR_W); a++) begin
            regfile[a] = {2{24'h5ac3e1, a[7:0]}};
        end
        fd = $fopen("bench/unpack_tests.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open bench/unpack_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] == "R") begin
                n = $sscanf(line, "R %h %h", f[0], rd);
                regfile[f[0][`UNPACK_VADDR_W-1:0]] = rd;
            end else if (line.len() > 1 && line[0] == "I") begin
                n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                if (n != 12) begin
                    other_errs++;
                    $display("item line in the test file has missing fields");
                end
                it                    = '0;
                it.ctrl               = f[0][`UNPACK_CTRL_W-1:0];
                it.eew                = eew_e'(f[1][1:0]);
                it.vs2.load           = f[2][0];
                it.vs2.is_vreg        = 1'b1;
                it.vs2.narrow         = f[3][0];
                it.vs2.sigext         = f[4][0];
                it.vs2.src.vreg.vaddr = f[5][`UNPACK_VADDR_W-1:0];
                it.vs1.load           = f[6][0];
                it.vs1.is_vreg        = f[7][0];
                it.vs1.src.xval       = f[8];
                items.push_back(it);
                e.ctrl = f[9][`UNPACK_CTRL_W-1:0];
                e.vs2  = f[10];
                e.vs1  = f[11];
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // output readiness held low at first so that items back up
    always @(posedge clk_i) begin
        cycle_cnt        <= cycle_cnt + 1;
        rnd_state        <= next_rand(rnd_state);
        pipe_out_ready_i <= (cycle_cnt >= HOLD_CYCLES) && (rnd_state[1:0] != 2'b00);
    end

    always @(posedge clk_i) begin
        if (async_rst_ni && pipe_out_valid_o && pipe_out_ready_i) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("output transfer seen after all items were already delivered");
            end else begin
                exp_item = exp_q.pop_front();
                check_ctrl("pipe_out_ctrl_o", pipe_out_ctrl_o, exp_item.ctrl);
                check_op("pipe_out_vs2_o", pipe_out_vs2_o, exp_item.vs2);
                check_op("pipe_out_vs1_o", pipe_out_vs1_o, exp_item.vs1);
            end
        end
        if (async_rst_ni && pipe_in_valid_i && !pipe_in_ready_o) begin
            want_mask = pending_bits(pipe_in_item_i);
            check_mask("pending_vreg_reads_o", pending_vreg_reads_o & want_mask, want_mask);
        end
    end

    initial begin
        wait (loaded);
        #((items.size() * 40 + RST_CYCLES + HOLD_CYCLES) * 20);
        $display("timeout: the pipeline did not deliver all items in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        async_rst_ni    = 1'b0;
        pipe_in_valid_i = 1'b0;
        pipe_in_item_i  = '0;
        read_tests();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        // nothing is valid before the first item
        repeat (3) begin
            @(posedge clk_i);
            if (pipe_out_valid_o || stage_valid_any_o) begin
                other_errs++;
                $display("a stage is valid before any item was sent");
            end
            check_mask("pending_vreg_reads_o", pending_vreg_reads_o, '0);
        end
        foreach (items[k]) begin
            pipe_in_valid_i <= 1'b1;
            pipe_in_item_i  <= items[k];
            @(posedge clk_i);
            while (!pipe_in_ready_o) @(posedge clk_i);
        end
        pipe_in_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        if (stage_valid_any_o) begin
            other_errs++;
            $display("pipeline still holds an item after all outputs were seen");
        end
        check_mask("pending_vreg_reads_o", pending_vreg_reads_o, '0);
        $display("errors: ctrl %0d, operand %0d, mask %0d, other %0d",
                 ctrl_errs, op_errs, mask_errs, other_errs);
        if (ctrl_errs + op_errs + mask_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/vreg_unpack_properties.sv ====
/*
 * handshake and reset checks bound into vreg_unpack
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module vreg_unpack_properties (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      out_valid_i,
    input  logic                      out_ready_i,
    input  logic [`UNPACK_CTRL_W-1:0] out_ctrl_i,
    input  logic [`UNPACK_OP_W-1:0]   out_vs2_i,
    input  logic [`UNPACK_OP_W-1:0]   out_vs1_i,
    input  logic                      any_valid_i
);

    assert property (@(posedge clk_i) $rose(async_rst_ni) |-> !out_valid_i)
        else $error("output valid high in the first cycle after reset");

    // a stalled output keeps its valid and its data
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i && !out_ready_i |=>
            out_valid_i && $stable({out_ctrl_i, out_vs2_i, out_vs1_i}))
        else $error("stalled output changed before it was taken");

    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i |-> any_valid_i)
        else $error("output valid while no stage is flagged valid");

endmodule

bind vreg_unpack vreg_unpack_properties props_i (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .out_valid_i  (pipe_out_valid_o),
    .out_ready_i  (pipe_out_ready_i),
    .out_ctrl_i   (pipe_out_ctrl_o),
    .out_vs2_i    (pipe_out_vs2_o),
    .out_vs1_i    (pipe_out_vs1_o),
    .any_valid_i  (stage_valid_any_o)
);

// ==== hdl/vreg_unpack.sv ====
/*
 * operand unpack pipeline, vs1 loads in stage 0 and vs2 in stage 1
 * the register file must answer read addresses in the same cycle
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module vreg_unpack (
    input  logic                                 clk_i,
    input  logic                                 async_rst_ni,
    input  logic                                 pipe_in_valid_i,
    output logic                                 pipe_in_ready_o,
    input  unpack_pkg::unpack_item_t             pipe_in_item_i,
    output logic                                 pipe_out_valid_o,
    input  logic                                 pipe_out_ready_i,
    output logic [`UNPACK_CTRL_W-1:0]            pipe_out_ctrl_o,
    output logic [`UNPACK_OP_W-1:0]              pipe_out_vs2_o,
    output logic [`UNPACK_OP_W-1:0]              pipe_out_vs1_o,
    output logic [1:0][`UNPACK_VADDR_W-1:0]      vreg_rd_addr_o,
    input  logic [1:0][`UNPACK_VPORT_W-1:0]      vreg_rd_data_i,
    output logic [(1 << `UNPACK_VADDR_W)-1:0]    pending_vreg_reads_o,
    output logic                                 stage_valid_any_o
);

    import unpack_pkg::*;

    logic [`UNPACK_STAGES:0]    stage_valid;
    logic [`UNPACK_STAGES:0]    stage_ready;
    logic [`UNPACK_STAGES-1:0]  upd_en;
    unpack_item_t               stage0_item;
    stage_item_t                stage1_item;
    stage_item_t                stage2_item;
    op_req_t                    vs2_load_req;
    logic [`UNPACK_VPORT_W-1:0] vs2_buf_q;
    logic [`UNPACK_VPORT_W-1:0] vs1_buf_q;
    logic [`UNPACK_OP_W-1:0]    vs1_data;

    unpack_pipe_ctrl pipe_ctrl_i (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_valid_i  (pipe_in_valid_i),
        .pipe_in_item_i   (pipe_in_item_i),
        .vs1_data_i       (vs1_data),
        .pipe_out_ready_i (pipe_out_ready_i),
        .stage_valid_o    (stage_valid),
        .stage0_item_o    (stage0_item),
        .stage1_item_o    (stage1_item),
        .stage2_item_o    (stage2_item),
        .stage_ready_o    (stage_ready),
        .upd_en_o         (upd_en)
    );

    vreg_read_track read_track_i (
        .stage_valid_i        (stage_valid),
        .stage0_item_i        (stage0_item),
        .stage1_item_i        (stage1_item),
        .vreg_rd_addr_o       (vreg_rd_addr_o),
        .pending_vreg_reads_o (pending_vreg_reads_o),
        .stage_valid_any_o    (stage_valid_any_o)
    );

    // vs2 is always a vector register
    always_comb begin
        vs2_load_req         = stage1_item.item.vs2;
        vs2_load_req.is_vreg = 1'b1;
    end

    operand_buffer vs2_buf (
        .clk_i       (clk_i),
        .upd_en_i    (upd_en[1]),
        .req_i       (vs2_load_req),
        .vreg_data_i (vreg_rd_data_i[0]),
        .buf_o       (vs2_buf_q)
    );

    operand_buffer vs1_buf (
        .clk_i       (clk_i),
        .upd_en_i    (upd_en[0]),
        .req_i       (stage0_item.vs1),
        .vreg_data_i (vreg_rd_data_i[1]),
        .buf_o       (vs1_buf_q)
    );

    operand_extract #(
        .ALLOW_XREG (1'b0)
    ) vs2_ext (
        .buf_i (vs2_buf_q),
        .req_i (stage2_item.item.vs2),
        .eew_i (stage2_item.item.eew),
        .op_o  (pipe_out_vs2_o)
    );

    operand_extract #(
        .ALLOW_XREG (1'b1)
    ) vs1_ext (
        .buf_i (vs1_buf_q),
        .req_i (stage1_item.item.vs1),
        .eew_i (stage1_item.item.eew),
        .op_o  (vs1_data)
    );

    assign pipe_in_ready_o  = stage_ready[0];
    assign pipe_out_valid_o = stage_valid[`UNPACK_STAGES];
    assign pipe_out_ctrl_o  = stage2_item.item.ctrl;
    assign pipe_out_vs1_o   = stage2_item.vs1_op;

endmodule

// ==== hdl/vreg_read_track.sv ====
/*
 * read addresses and mask of vector registers not yet read
 * vs1 is read in stage 0 and vs2 in stage 1
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module vreg_read_track (
    input  logic [`UNPACK_STAGES:0]                  stage_valid_i,
    input  unpack_pkg::unpack_item_t                 stage0_item_i,
    input  unpack_pkg::stage_item_t                  stage1_item_i,
    output logic [1:0][`UNPACK_VADDR_W-1:0]          vreg_rd_addr_o,
    output logic [(1 << `UNPACK_VADDR_W)-1:0]        pending_vreg_reads_o,
    output logic                                     stage_valid_any_o
);

    // port 0 serves vs2, port 1 serves vs1
    assign vreg_rd_addr_o[0] = stage1_item_i.item.vs2.src.vreg.vaddr;
    assign vreg_rd_addr_o[1] = stage0_item_i.vs1.src.vreg.vaddr;

    // an operand is pending in every valid stage up to its load stage
    always_comb begin
        pending_vreg_reads_o = '0;
        if (stage_valid_i[0] && stage0_item_i.vs2.load) begin
            pending_vreg_reads_o[stage0_item_i.vs2.src.vreg.vaddr] = 1'b1;
        end
        if (stage_valid_i[0] && stage0_item_i.vs1.load && stage0_item_i.vs1.is_vreg) begin
            pending_vreg_reads_o[stage0_item_i.vs1.src.vreg.vaddr] = 1'b1;
        end
        if (stage_valid_i[1] && stage1_item_i.item.vs2.load) begin
            pending_vreg_reads_o[stage1_item_i.item.vs2.src.vreg.vaddr] = 1'b1;
        end
    end

    assign stage_valid_any_o = |stage_valid_i;

endmodule

// ==== hdl/operand_extract.sv ====
/*
 * turns the low buffer bits or a scalar into one 32-bit operand
 * narrow requests at eew 8 are not extended and pass the buffer bits
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module operand_extract #(
    parameter bit ALLOW_XREG = 1'b0
) (
    input  logic [`UNPACK_VPORT_W-1:0]  buf_i,
    input  unpack_pkg::op_req_t         req_i,
    input  unpack_pkg::eew_e            eew_i,
    output logic [`UNPACK_OP_W-1:0]     op_o
);

    import unpack_pkg::*;

    always_comb begin
        op_o = buf_i[`UNPACK_OP_W-1:0];

        // each narrow element grows to twice its width
        if (req_i.narrow) begin
            case (eew_i)
                EEW_16: begin
                    for (int j = 0; j < `UNPACK_OP_W / 16; j++) begin
                        op_o[16*j +: 16] = {{8{req_i.sigext & buf_i[8*j+7]}}, buf_i[8*j +: 8]};
                    end
                end
                EEW_32: begin
                    op_o = {{16{req_i.sigext & buf_i[15]}}, buf_i[15:0]};
                end
                default: ;
            endcase
        end

        // scalar is repeated across the operand at element width
        if (ALLOW_XREG && !req_i.is_vreg) begin
            case (eew_i)
                EEW_8:   op_o = {(`UNPACK_OP_W / 8){req_i.src.xval[7:0]}};
                EEW_16:  op_o = {(`UNPACK_OP_W / 16){req_i.src.xval[15:0]}};
                default: op_o = req_i.src.xval;
            endcase
        end
    end

endmodule

// ==== hdl/operand_buffer.sv ====
/*
 * 64-bit operand buffer, written only on edges where upd_en_i is high
 * a scalar load keeps the old contents, the extractor reads the scalar itself
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module operand_buffer (
    input  logic                          clk_i,
    input  logic                          upd_en_i,
    input  unpack_pkg::op_req_t           req_i,
    input  logic [`UNPACK_VPORT_W-1:0]    vreg_data_i,
    output logic [`UNPACK_VPORT_W-1:0]    buf_o
);

    // consume steps for full and narrow operands
    localparam int unsigned FULL_STEP   = `UNPACK_OP_W;
    localparam int unsigned NARROW_STEP = `UNPACK_OP_W / 2;

    logic [`UNPACK_VPORT_W-1:0] buf_q;
    logic [`UNPACK_VPORT_W-1:0] buf_d;

    always_comb begin
        buf_d = buf_q;
        if (req_i.load) begin
            if (req_i.is_vreg) begin
                buf_d = vreg_data_i;
            end
        end else if (req_i.narrow) begin
            // narrow elements are doubled, so half an operand is used up
            buf_d = buf_q >> NARROW_STEP;
        end else begin
            buf_d = buf_q >> FULL_STEP;
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_en_i) begin
            buf_q <= buf_d;
        end
    end

    assign buf_o = buf_q;

endmodule

// ==== hdl/unpack_pipe_ctrl.sv ====
/*
 * stage 0 is the pipeline input itself, stages 1 and 2 are registers
 * stage_ready_o[i] is high when the item in stage i may move on
 */

`timescale 1ns/1ps
`include "unpack_defs.svh"

module unpack_pipe_ctrl (
    input  logic                         clk_i,
    input  logic                         async_rst_ni,
    input  logic                         pipe_in_valid_i,
    input  unpack_pkg::unpack_item_t     pipe_in_item_i,
    input  logic [`UNPACK_OP_W-1:0]      vs1_data_i,
    input  logic                         pipe_out_ready_i,
    output logic [`UNPACK_STAGES:0]      stage_valid_o,
    output unpack_pkg::unpack_item_t     stage0_item_o,
    output unpack_pkg::stage_item_t      stage1_item_o,
    output unpack_pkg::stage_item_t      stage2_item_o,
    output logic [`UNPACK_STAGES:0]      stage_ready_o,
    output logic [`UNPACK_STAGES-1:0]    upd_en_o
);

    import unpack_pkg::*;

    logic [`UNPACK_STAGES:1] stage_valid_q;
    stage_item_t             stage1_q;
    stage_item_t             stage2_q;

    assign stage_valid_o = {stage_valid_q, pipe_in_valid_i};

    // a stage moves on when the output takes an item or a later stage is empty
    always_comb begin
        stage_ready_o[`UNPACK_STAGES] = pipe_out_ready_i;
        for (int i = `UNPACK_STAGES - 1; i >= 0; i--) begin
            stage_ready_o[i] = stage_ready_o[i+1] | ~stage_valid_o[i+1];
        end
    end

    // stage k hands its item over to stage k+1
    assign upd_en_o = stage_valid_o[`UNPACK_STAGES-1:0] & stage_ready_o[`UNPACK_STAGES-1:0];

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage_valid_q <= '0;
        end else begin
            if (stage_ready_o[0]) begin
                stage_valid_q[1] <= pipe_in_valid_i;
            end
            if (stage_ready_o[1]) begin
                stage_valid_q[2] <= stage_valid_q[1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_en_o[0]) begin
            stage1_q.item   <= pipe_in_item_i;
            stage1_q.vs1_op <= '0;
        end
        // vs1 is unpacked in stage 1 and registered on the way into stage 2
        if (upd_en_o[1]) begin
            stage2_q.item   <= stage1_q.item;
            stage2_q.vs1_op <= vs1_data_i;
        end
    end

    assign stage0_item_o = pipe_in_item_i;
    assign stage1_item_o = stage1_q;
    assign stage2_item_o = stage2_q;

endmodule

// ==== hdl/unpack_pkg.sv ====
/*
 * types shared by the unpack pipeline
 * the source word of a request is either a vreg address or an X-register value
 */

`include "unpack_defs.svh"

package unpack_pkg;

    // element width of the current item
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef struct packed {
        logic [`UNPACK_OP_W-`UNPACK_VADDR_W-1:0] pad;
        logic [`UNPACK_VADDR_W-1:0]              vaddr;
    } vreg_src_t;

    // one source word, decoded as a register address or as a scalar
    typedef union packed {
        vreg_src_t               vreg;
        logic [`UNPACK_OP_W-1:0] xval;
    } op_src_u;

    typedef struct packed {
        logic    load;
        logic    is_vreg;
        logic    narrow;
        logic    sigext;
        op_src_u src;
    } op_req_t;

    typedef struct packed {
        logic [`UNPACK_CTRL_W-1:0] ctrl;
        eew_e                      eew;
        op_req_t                   vs2;
        op_req_t                   vs1;
    } unpack_item_t;

    // vs1_op is filled when the item enters the last stage
    typedef struct packed {
        unpack_item_t            item;
        logic [`UNPACK_OP_W-1:0] vs1_op;
    } stage_item_t;

endpackage

// ==== hdl/unpack_defs.svh ====
/*
 * widths and depth of the operand unpack pipeline
 * UNPACK_VPORT_W must be twice UNPACK_OP_W for the 32-bit consume step
 */

`ifndef UNPACK_DEFS_SVH
`define UNPACK_DEFS_SVH

// vector register read port width
`define UNPACK_VPORT_W 64

// width of one unpacked operand
`define UNPACK_OP_W 32

// vector register address width, 32 registers
`define UNPACK_VADDR_W 5

// control word carried along with each item
`define UNPACK_CTRL_W 8

// register stages after the input stage
`define UNPACK_STAGES 2

`endif
